// File: design/isa_pkg.sv
package isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths and fixed addresses
    ////////////////////////////////////////////////////////////////////////////

    // Address bus width
    localparam int ADDR_W = 16;
    // Data bus width
    localparam int DATA_W = 8;

    // Low byte of reset vector, high byte follows
    localparam logic [ADDR_W-1:0] RESET_VECTOR = 16'hFFFC;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes of the supported subset
    ////////////////////////////////////////////////////////////////////////////

    // Standard 6502 encodings
    typedef enum logic [7:0] {
        // Immediate operand
        LDA_IMM = 8'hA9,
        ADC_IMM = 8'h69,
        AND_IMM = 8'h29,
        // Implied
        TAX     = 8'hAA,
        INX     = 8'hE8,
        CLC     = 8'h18,
        SEC     = 8'h38,
        NOP     = 8'hEA,
        // Absolute address
        STA_ABS = 8'h8D,
        STX_ABS = 8'h8E,
        JMP_ABS = 8'h4C,
        // Relative branch
        BNE     = 8'hD0
    } opcode_e;

    ////////////////////////////////////////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        PASS,   // Result is operand b
        ADD_C,  // a + b + carry
        AND,    // a & b
        INC,    // a + 1
        SET_C,  // Carry only
        CLR_C   // Carry only
    } alu_op_e;

endpackage

// File: design/core_pkg.sv
package core_pkg;

    // Cycle states of the sequencer
    typedef enum logic [2:0] {
        VEC_LO,
        VEC_HI,
        FETCH,
        OPERAND,
        ADDR_HI,
        WRITE,
        IDLE
    } cpu_state_e;

    // Bus address source
    typedef enum logic [1:0] {
        PC,
        VECTOR_LO,
        VECTOR_HI,
        ABS
    } addr_sel_e;

    // Per-cycle control word, sequencer to datapath
    typedef struct packed {
        addr_sel_e        addr_sel;
        logic             pc_inc;
        logic             pc_load_vec_lo;
        logic             pc_load_vec_hi;
        logic             pc_jump;
        logic             pc_branch;
        logic             latch_lo;
        logic             a_load;
        logic             x_load;
        logic             x_from_a;
        isa_pkg::alu_op_e alu_op;
        logic             write_en;
        logic             write_x;
    } ctrl_t;

    // One bus access per cycle
    typedef struct packed {
        logic [isa_pkg::ADDR_W-1:0] addr;
        logic                       rwb;
        logic [isa_pkg::DATA_W-1:0] wdata;
    } mem_req_t;

    // Quiet control word, read at PC with nothing loaded
    localparam ctrl_t CTRL_NONE = '{addr_sel: PC, alu_op: isa_pkg::PASS, default: 1'b0};

endpackage

// File: design/alu_flags.sv
`timescale 1ns/1ns

module alu_flags (
    input  logic                       fclk,
    input  logic                       reset,
    input  isa_pkg::alu_op_e           op,
    input  logic [isa_pkg::DATA_W-1:0] a,
    input  logic [isa_pkg::DATA_W-1:0] b,
    input  logic                       update,
    output logic [isa_pkg::DATA_W-1:0] result,
    output logic                       zero
);

    import isa_pkg::*;

    logic              carry;
    // One extra bit for carry out
    logic [DATA_W:0]   sum;

    ////////////////////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////////////////////

    assign sum = {1'b0, a} + {1'b0, b} + {{DATA_W{1'b0}}, carry};

    always_comb begin
        case (op)
            ADD_C:   result = sum[DATA_W-1:0];
            AND:     result = a & b;
            // Wraps at FF
            INC:     result = a + 8'd1;
            // PASS, and carry ops where result is unused
            default: result = b;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Carry and zero flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge fclk) begin
        if (reset) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (update) begin
            case (op)
                SET_C: carry <= 1'b1;
                CLR_C: carry <= 1'b0;
                ADD_C: begin
                    carry <= sum[DATA_W];
                    zero  <= (result == '0);
                end
                // Loads, AND and INC leave carry alone
                default: zero <= (result == '0);
            endcase
        end
    end

    // Flags must never capture X from upstream
    assert property (@(posedge fclk) disable iff (reset) update |-> !$isunknown(result));

endmodule

// File: design/datapath.sv
`timescale 1ns/1ns

module datapath (
    input  logic                       fclk,
    input  logic                       reset,
    input  logic [isa_pkg::DATA_W-1:0] rdata,
    input  core_pkg::ctrl_t            ctrl,
    output core_pkg::mem_req_t         mem,
    output logic                       zero
);

    import isa_pkg::*;
    import core_pkg::*;

    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] pc_seq;
    logic [ADDR_W-1:0] branch_offset;
    // Operand bytes, newest in the high half
    logic [ADDR_W-1:0] abs_addr;
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] x;
    logic [DATA_W-1:0] alu_a;
    logic [DATA_W-1:0] alu_b;
    logic [DATA_W-1:0] alu_result;
    logic              flag_update;

    ////////////////////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////////////////////

    assign pc_seq = pc + 16'd1;
    // Sign extend the branch byte
    assign branch_offset = {{(ADDR_W-DATA_W){rdata[DATA_W-1]}}, rdata};

    always_ff @(posedge fclk) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pc_load_vec_lo) begin
            pc[DATA_W-1:0] <= rdata;
        end else if (ctrl.pc_load_vec_hi) begin
            pc[ADDR_W-1:DATA_W] <= rdata;
        end else if (ctrl.pc_jump) begin
            // High byte on the bus, low byte latched one cycle earlier
            pc <= {rdata, abs_addr[ADDR_W-1:DATA_W]};
        end else if (ctrl.pc_branch) begin
            // Relative to the byte after the operand
            pc <= pc_seq + branch_offset;
        end else if (ctrl.pc_inc) begin
            pc <= pc_seq;
        end
    end

    // Absolute operand shifts in low then high
    always_ff @(posedge fclk) begin
        if (ctrl.latch_lo) begin
            abs_addr <= {rdata, abs_addr[ADDR_W-1:DATA_W]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // A, X and ALU
    ////////////////////////////////////////////////////////////////////////////

    // X ops work on X, everything else on A
    assign alu_a = ctrl.x_load ? x : acc;
    // TAX passes A, immediates take the bus byte
    assign alu_b = ctrl.x_from_a ? acc : rdata;

    assign flag_update = ctrl.a_load || ctrl.x_load ||
                         ctrl.alu_op == SET_C || ctrl.alu_op == CLR_C;

    alu_flags alu_flags_i (
        .fclk   (fclk),
        .reset  (reset),
        .op     (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .update (flag_update),
        .result (alu_result),
        .zero   (zero)
    );

    always_ff @(posedge fclk) begin
        if (reset) begin
            acc <= '0;
            x   <= '0;
        end else begin
            if (ctrl.a_load) begin
                acc <= alu_result;
            end
            if (ctrl.x_load) begin
                x <= alu_result;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory request
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.addr_sel)
            VECTOR_LO: mem.addr = RESET_VECTOR;
            VECTOR_HI: mem.addr = RESET_VECTOR + 16'd1;
            ABS:       mem.addr = abs_addr;
            default:   mem.addr = pc;
        endcase
        mem.rwb   = !ctrl.write_en;
        // STX stores X, STA stores A
        mem.wdata = ctrl.write_x ? x : acc;
    end

    // Writes go only to the latched absolute address
    assert property (@(posedge fclk) disable iff (reset) !mem.rwb |-> ctrl.addr_sel == ABS);

endmodule

// File: design/sequencer.sv
`timescale 1ns/1ns

module sequencer (
    input  logic                       fclk,
    input  logic                       reset,
    input  logic [isa_pkg::DATA_W-1:0] rdata,
    input  logic                       zero,
    output core_pkg::ctrl_t            ctrl,
    output logic                       sync
);

    import isa_pkg::*;
    import core_pkg::*;

    cpu_state_e state;
    cpu_state_e state_next;
    // Opcode of the running instruction
    opcode_e    ir;

    // Opcodes that read at least one byte after the opcode
    function automatic logic needs_operand(input opcode_e op);
        case (op)
            LDA_IMM, ADC_IMM, AND_IMM, BNE, JMP_ABS, STA_ABS, STX_ABS: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // State and instruction register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge fclk) begin
        if (reset) begin
            state <= VEC_LO;
        end else begin
            state <= state_next;
        end
    end

    // Opcode sits on rdata during FETCH
    always_ff @(posedge fclk) begin
        if (state == FETCH) begin
            ir <= opcode_e'(rdata);
        end
    end

    assign sync = (state == FETCH);

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            VEC_LO:  state_next = VEC_HI;
            VEC_HI:  state_next = FETCH;
            // Decode straight off the bus, ir not loaded yet
            FETCH:   state_next = needs_operand(opcode_e'(rdata)) ? OPERAND : IDLE;
            OPERAND: begin
                if (ir == JMP_ABS || ir == STA_ABS || ir == STX_ABS) begin
                    state_next = ADDR_HI;
                end else begin
                    state_next = FETCH;
                end
            end
            ADDR_HI: state_next = (ir == JMP_ABS) ? FETCH : WRITE;
            default: state_next = FETCH;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl = CTRL_NONE;
        case (state)
            VEC_LO: begin
                ctrl.addr_sel       = VECTOR_LO;
                ctrl.pc_load_vec_lo = 1'b1;
            end
            VEC_HI: begin
                ctrl.addr_sel       = VECTOR_HI;
                ctrl.pc_load_vec_hi = 1'b1;
            end
            FETCH: begin
                ctrl.pc_inc = 1'b1;
            end
            OPERAND: begin
                ctrl.pc_inc = 1'b1;
                case (ir)
                    LDA_IMM: begin
                        ctrl.a_load = 1'b1;
                        ctrl.alu_op = PASS;
                    end
                    ADC_IMM: begin
                        ctrl.a_load = 1'b1;
                        ctrl.alu_op = ADD_C;
                    end
                    AND_IMM: begin
                        ctrl.a_load = 1'b1;
                        ctrl.alu_op = AND;
                    end
                    // Only test of the zero flag
                    BNE: ctrl.pc_branch = !zero;
                    default: ctrl.latch_lo = 1'b1;
                endcase
            end
            ADDR_HI: begin
                ctrl.latch_lo = 1'b1;
                if (ir == JMP_ABS) begin
                    ctrl.pc_jump = 1'b1;
                end else begin
                    ctrl.pc_inc = 1'b1;
                end
            end
            WRITE: begin
                ctrl.addr_sel = ABS;
                ctrl.write_en = 1'b1;
                ctrl.write_x  = (ir == STX_ABS);
            end
            default: begin
                // IDLE re-reads PC, implied ops act here
                case (ir)
                    TAX: begin
                        ctrl.x_load   = 1'b1;
                        ctrl.x_from_a = 1'b1;
                    end
                    INX: begin
                        ctrl.x_load = 1'b1;
                        ctrl.alu_op = INC;
                    end
                    CLC: ctrl.alu_op = CLR_C;
                    SEC: ctrl.alu_op = SET_C;
                    default: ctrl.alu_op = PASS;
                endcase
            end
        endcase
    end

    // Stores are single cycle, always followed by a fetch
    assert property (@(posedge fclk) disable iff (reset) ctrl.write_en |=> !ctrl.write_en);

    // Two vector reads before the first opcode
    assert property (@(posedge fclk)
        $fell(reset) |-> state == VEC_LO ##1 state == VEC_HI ##1 state == FETCH);

endmodule

// File: design/m65_top.sv
`timescale 1ns/1ns

module m65_top (
    input  logic                       fclk,
    input  logic                       reset,
    input  logic [isa_pkg::DATA_W-1:0] rdata,
    output core_pkg::mem_req_t         mem,
    output logic                       sync
);

    import core_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Internal connections
    ////////////////////////////////////////////////////////////////////////////

    // Control word, valid in the same cycle
    ctrl_t ctrl;
    // Zero flag back to the branch decision
    logic  zero;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction sequencing
    ////////////////////////////////////////////////////////////////////////////

    sequencer sequencer_i (
        .fclk  (fclk),
        .reset (reset),
        .rdata (rdata),
        .zero  (zero),
        .ctrl  (ctrl),
        .sync  (sync)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Registers, ALU and bus drive
    ////////////////////////////////////////////////////////////////////////////

    datapath datapath_i (
        .fclk  (fclk),
        .reset (reset),
        .rdata (rdata),
        .ctrl  (ctrl),
        .mem   (mem),
        .zero  (zero)
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic fclk,
    output logic reset
);

    // Free running clock, low at time zero
    initial begin
        fclk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            fclk = ~fclk;
        end
    end

    // Reset held for a fixed number of rising edges
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge fclk);
        // Release away from the sampling edge
        @(negedge fclk);
        reset = 1'b0;
    end

endmodule

// File: testbench/tb_memory.sv
`timescale 1ns/1ns

module tb_memory (
    input  logic                       fclk,
    input  core_pkg::mem_req_t         mem,
    output logic [isa_pkg::DATA_W-1:0] rdata
);

    import isa_pkg::*;

    // Full 64 KiB address space
    logic [DATA_W-1:0] ram [0:(1 << ADDR_W)-1];

    ////////////////////////////////////////////////////////////////////////////
    // Background fill
    ////////////////////////////////////////////////////////////////////////////

    // Both address bytes folded in, so no two pages look alike
    initial begin
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            ram[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////////////////////////////////////////

    // Write taken at the edge that ends the write cycle
    always @(posedge fclk) begin
        if (mem.rwb === 1'b0) begin
            ram[mem.addr] <= mem.wdata;
        end
    end

    // Same-cycle read, zero until the address settles
    assign rdata = $isunknown(mem.addr) ? '0 : ram[mem.addr];

endmodule

// File: testbench/tb_m65.sv
`timescale 1ns/1ns

module tb_m65;

    import isa_pkg::*;
    import core_pkg::*;

    localparam int CLK_PERIOD_NS = 8;
    localparam int RESET_CYCLES  = 2;
    localparam int MAX_STORES    = 32;
    localparam int MAX_TESTS     = 8;

    logic              fclk;
    logic              reset;
    logic [DATA_W-1:0] rdata;
    mem_req_t          mem;
    logic              sync;

    // Program layout and marker addresses
    logic [ADDR_W-1:0] build_pc;
    logic [ADDR_W-1:0] prog_start = '0;
    logic [ADDR_W-1:0] jmp_at     = '0;
    logic [ADDR_W-1:0] jmp_to     = '0;
    logic [ADDR_W-1:0] unk_at     = '0;
    logic [ADDR_W-1:0] test_end [MAX_TESTS];
    string             test_name [MAX_TESTS];
    int                n_tests    = 0;

    // Expected stores in program order
    logic [ADDR_W-1:0] exp_addr [MAX_STORES];
    logic [DATA_W-1:0] exp_data [MAX_STORES];
    int                n_exp      = 0;
    int                store_idx  = 0;

    // Architectural model of A, X, carry and zero
    logic [DATA_W-1:0] m_a;
    logic [DATA_W-1:0] m_x;
    logic              m_c;
    logic              m_z;
    int                model_cycles = 0;

    int                errors     = 0;
    int                cycle      = 0;
    bit                program_ready = 1'b0;

    ////////////////////////////////////////////////////////////////////////////
    // Clock, memory and DUT
    ////////////////////////////////////////////////////////////////////////////

    tb_clock #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_i (
        .fclk  (fclk),
        .reset (reset)
    );

    tb_memory memory_i (
        .fclk  (fclk),
        .mem   (mem),
        .rdata (rdata)
    );

    m65_top m65_top_i (
        .fclk  (fclk),
        .reset (reset),
        .rdata (rdata),
        .mem   (mem),
        .sync  (sync)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Program building with the reference model alongside
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [DATA_W-1:0] rand_byte();
        logic [31:0] word;
        word = $urandom;
        return word[7:0];
    endfunction

    task automatic put_byte(input logic [DATA_W-1:0] b);
        memory_i.ram[build_pc] = b;
        build_pc = build_pc + 16'd1;
    endtask

    task automatic expect_store(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        exp_addr[n_exp] = addr;
        exp_data[n_exp] = data;
        n_exp++;
    endtask

    // Zero follows the new A after any immediate op
    task automatic run_imm(input opcode_e op, input logic [DATA_W-1:0] v);
        int total;
        put_byte(op);
        put_byte(v);
        case (op)
            LDA_IMM: m_a = v;
            AND_IMM: m_a = m_a & v;
            default: begin
                // Sum modulo 256 with carry out when it passes FF
                total = m_a + v + m_c;
                m_a = 8'(total % 256);
                m_c = (total > 255);
            end
        endcase
        m_z = (m_a == '0);
        model_cycles += 2;
    endtask

    // Unlisted single byte ops change nothing
    task automatic run_implied(input logic [DATA_W-1:0] op);
        put_byte(op);
        case (op)
            TAX: begin
                m_x = m_a;
                m_z = (m_x == '0);
            end
            INX: begin
                m_x = m_x + 8'd1;
                m_z = (m_x == '0);
            end
            CLC: m_c = 1'b0;
            SEC: m_c = 1'b1;
            default: ;
        endcase
        model_cycles += 2;
    endtask

    task automatic run_store(input opcode_e op, input logic [ADDR_W-1:0] addr);
        put_byte(op);
        put_byte(addr[7:0]);
        put_byte(addr[15:8]);
        expect_store(addr, (op == STX_ABS) ? m_x : m_a);
        model_cycles += 4;
    endtask

    // Builder follows the jump and leaves the skipped bytes as fill
    task automatic run_jmp(input logic [ADDR_W-1:0] target);
        jmp_at = build_pc;
        jmp_to = target;
        put_byte(JMP_ABS);
        put_byte(target[7:0]);
        put_byte(target[15:8]);
        build_pc = target;
        model_cycles += 3;
    endtask

    // The STA after BNE only stores when zero is set
    task automatic run_bne_over_store(input logic [ADDR_W-1:0] addr);
        put_byte(BNE);
        put_byte(8'h03);
        model_cycles += 2;
        if (m_z) begin
            run_store(STA_ABS, addr);
        end else begin
            put_byte(STA_ABS);
            put_byte(addr[7:0]);
            put_byte(addr[15:8]);
        end
    endtask

    // A test ends where the next one starts fetching
    task automatic finish_test(input string name);
        test_end[n_tests]  = build_pc;
        test_name[n_tests] = name;
        n_tests++;
    endtask

    task automatic build_program();
        logic [31:0] word;
        logic [ADDR_W-1:0] loop_at;
        word = $urandom;
        prog_start = 16'h0400 + {4'h0, word[11:0]};
        memory_i.ram[RESET_VECTOR]         = prog_start[7:0];
        memory_i.ram[RESET_VECTOR + 16'd1] = prog_start[15:8];
        build_pc = prog_start;
        m_a = '0;
        m_x = '0;
        m_c = 1'b0;
        m_z = 1'b0;
        finish_test("reset and vector");

        run_imm(LDA_IMM, rand_byte());
        run_imm(AND_IMM, rand_byte());
        run_store(STA_ABS, 16'hA000);
        finish_test("load, logic and store");

        // With and without the carry in
        run_implied(SEC);
        run_imm(LDA_IMM, rand_byte());
        run_imm(ADC_IMM, rand_byte());
        run_store(STA_ABS, 16'hA001);
        run_implied(CLC);
        run_imm(LDA_IMM, rand_byte());
        run_imm(ADC_IMM, rand_byte());
        run_store(STA_ABS, 16'hA002);
        // Both top bits set so the first sum overflows
        run_implied(CLC);
        run_imm(LDA_IMM, rand_byte() | 8'h80);
        run_imm(ADC_IMM, rand_byte() | 8'h80);
        run_imm(ADC_IMM, rand_byte());
        run_store(STA_ABS, 16'hA003);
        finish_test("add with carry");

        run_imm(LDA_IMM, rand_byte());
        run_implied(TAX);
        run_implied(INX);
        run_implied(INX);
        run_store(STX_ABS, 16'hA004);
        // FE + 2 wraps to 00
        run_imm(LDA_IMM, 8'hFE);
        run_implied(TAX);
        run_implied(INX);
        run_implied(INX);
        run_store(STX_ABS, 16'hA005);
        finish_test("index register");

        run_jmp(build_pc + 16'd7);
        // Branch skips the poison store after a non-zero load
        run_imm(LDA_IMM, rand_byte() | 8'h01);
        run_bne_over_store(16'hBEEF);
        run_imm(LDA_IMM, rand_byte());
        run_imm(AND_IMM, 8'h00);
        run_bne_over_store(16'hA006);
        finish_test("control flow");

        run_imm(LDA_IMM, rand_byte());
        run_implied(TAX);
        run_implied(SEC);
        unk_at = build_pc;
        run_implied(8'h02);
        run_store(STA_ABS, 16'hA007);
        run_store(STX_ABS, 16'hA008);
        // Carry must survive the unknown opcode
        run_imm(ADC_IMM, 8'h00);
        run_store(STA_ABS, 16'hA009);
        finish_test("unknown opcode");

        // Park on a jump to itself
        loop_at = build_pc;
        put_byte(JMP_ABS);
        put_byte(loop_at[7:0]);
        put_byte(loop_at[15:8]);
        model_cycles += 3;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus checks
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge fclk) begin
        cycle <= cycle + 1;
        if (!reset && !mem.rwb) begin
            store_idx <= store_idx + 1;
        end
    end

    // Skip the edge before reset has reached the state
    assert property (@(posedge fclk) reset && cycle > 0 |-> mem.rwb && !sync)
        else begin
            errors++;
            $display("Bus was not idle during reset at %0t ns", $time);
        end

    assert property (@(posedge fclk) $fell(reset) |->
        mem.addr == RESET_VECTOR ##1 mem.addr == RESET_VECTOR + 16'd1
        ##1 (sync && mem.addr == prog_start))
        else begin
            errors++;
            $display("Vector reads or first fetch address were wrong at %0t ns", $time);
        end

    // Each write matches the next expected store
    assert property (@(posedge fclk) disable iff (reset)
        !mem.rwb |-> store_idx < n_exp && mem.addr == exp_addr[store_idx]
                     && mem.wdata == exp_data[store_idx])
        else begin
            errors++;
            $display("ERROR %0t ns: write of %h at address %h, expected %h at %h", $time,
                     $sampled(mem.wdata), $sampled(mem.addr),
                     exp_data[$sampled(store_idx)], exp_addr[$sampled(store_idx)]);
        end

    // Store lands 3 cycles after its fetch and the next fetch follows
    assert property (@(posedge fclk) disable iff (reset)
        !mem.rwb |-> $past(sync, 3) && !$past(sync, 2) && !$past(sync) ##1 sync)
        else begin
            errors++;
            $display("Store cycle count was wrong at %0t ns", $time);
        end

    assert property (@(posedge fclk) disable iff (reset)
        sync && mem.addr == jmp_at |-> ##3 (sync && mem.addr == jmp_to))
        else begin
            errors++;
            $display("Jump did not reach its target at %0t ns", $time);
        end

    assert property (@(posedge fclk) disable iff (reset)
        sync && mem.addr == unk_at |-> ##1 !sync ##1 (sync && mem.addr == unk_at + 16'd1))
        else begin
            errors++;
            $display("Unknown opcode did not take two cycles at %0t ns", $time);
        end

    ////////////////////////////////////////////////////////////////////////////
    // Run control and reporting
    ////////////////////////////////////////////////////////////////////////////

    // One more edge after the fetch lets checks ending there complete
    task automatic wait_for_sync_at(input logic [ADDR_W-1:0] addr);
        do begin
            @(negedge fclk);
        end while (!(sync === 1'b1 && mem.addr === addr));
        @(negedge fclk);
    endtask

    initial begin
        int test_errors;
        int tests_failed;
        tests_failed = 0;
        void'($urandom(6));
        // Fill is done by the first falling edge after a rising one
        @(posedge fclk);
        @(negedge fclk);
        build_program();
        program_ready = 1'b1;
        for (int t = 0; t < n_tests; t++) begin
            test_errors = errors;
            wait_for_sync_at(test_end[t]);
            if (t == n_tests - 1) begin
                assert (store_idx == n_exp)
                    else begin
                        errors++;
                        $display("Only %0d of %0d expected stores happened", store_idx, n_exp);
                    end
            end
            if (errors != test_errors) begin
                tests_failed++;
            end
            $display("test %0d %s: %s", t + 1, test_name[t],
                     (errors == test_errors) ? "ok" : "failed");
        end
        $display("%0d tests, %0d failed, %0d check errors", n_tests, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Twice the modelled run length plus reset
    initial begin
        int limit_ns;
        wait (program_ready);
        limit_ns = 2 * model_cycles * CLK_PERIOD_NS + RESET_CYCLES * CLK_PERIOD_NS;
        #(limit_ns);
        $display("Watchdog expired, the program did not finish within %0d ns", limit_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: sim.f
design/isa_pkg.sv
design/core_pkg.sv
design/alu_flags.sv
design/datapath.sv
design/sequencer.sv
design/m65_top.sv
testbench/tb_clock.sv
testbench/tb_memory.sv
testbench/tb_m65.sv

// File: Bender.yml
package:
  name: m65

sources:
  - design/isa_pkg.sv
  - design/core_pkg.sv
  - design/alu_flags.sv
  - design/datapath.sv
  - design/sequencer.sv
  - design/m65_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_memory.sv
      - testbench/tb_m65.sv
